//--- all.f
source/osc_pkg.sv
source/plot_pkg.sv
source/spring_solver.sv
source/sample_fifo.sv
source/trace_plotter.sv
source/oscillator_display.sv
sim/credit_chk.sv
sim/plot_scoreboard.sv
sim/oscillator_display_tb.sv

//--- sim/oscillator_display_tb.sv
`timescale 1ns/1ps
`default_nettype none

module oscillator_display_tb;
  import osc_pkg::*;
  import plot_pkg::*;

  localparam int FIFO_DEPTH = 4;
  localparam int DT_SHIFT   = 9;
  localparam int STEP_DIV   = 4;
  localparam int SCREEN_W   = 48;  // small, so the column wraps
  localparam int X1_ROW     = 160;
  localparam int X2_ROW     = 400;
  localparam int N_ROWS     = 6;

  typedef struct {
    state_t k1;
    state_t kmid;
    state_t k2;
    state_t damp;
    state_t x1_init;
    state_t x2_init;
    state_t v1_init;
    state_t v2_init;
    int     samples;
    int     duty;     // pix_ready duty in percent
    int     end_col;  // samples modulo SCREEN_W
  } row_t;

  row_t tab [N_ROWS];

  logic             AnalogClock;
  logic             reset;
  logic             load;
  state_t           k1;
  state_t           kmid;
  state_t           k2;
  state_t           damp;
  state_t           x1_init;
  state_t           x2_init;
  state_t           v1_init;
  state_t           v2_init;
  logic             pix_ready;
  logic             pix_valid;
  logic [COL_W-1:0] pix_col;
  logic [ROW_W-1:0] pix_row;
  logic             pix_trace;
  int               target;
  logic [COL_W-1:0] exp_col;
  logic             row_done;
  int               write_errs;
  int               row_errs;
  int               cycles;
  int               limit;

  oscillator_display #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .DT_SHIFT   (DT_SHIFT),
    .STEP_DIV   (STEP_DIV),
    .SCREEN_W   (SCREEN_W),
    .X1_ROW     (X1_ROW),
    .X2_ROW     (X2_ROW)
  ) i_dut (.*);

  plot_scoreboard #(
    .DT_SHIFT (DT_SHIFT),
    .SCREEN_W (SCREEN_W),
    .X1_ROW   (X1_ROW),
    .X2_ROW   (X2_ROW)
  ) i_scoreboard (.*);

  always #5 AnalogClock = !AnalogClock;

  function automatic logic ready_draw(input int duty);
    if (duty >= 100)
      return 1'b1;
    return ($urandom % 100) < duty;
  endfunction

  task automatic print_counts();
    $display("errors: %0d pixel write, %0d row end, %0d assertion",
             write_errs, row_errs, i_dut.i_solver.i_credit_chk.assert_errs);
  endtask

  // one load cycle, then random ready until the row has its samples
  task automatic run_row(input int r);
    @(negedge AnalogClock);
    k1        = tab[r].k1;
    kmid      = tab[r].kmid;
    k2        = tab[r].k2;
    damp      = tab[r].damp;
    x1_init   = tab[r].x1_init;
    x2_init   = tab[r].x2_init;
    v1_init   = tab[r].v1_init;
    v2_init   = tab[r].v2_init;
    target    = tab[r].samples;
    exp_col   = COL_W'(tab[r].end_col);
    pix_ready = 1'b0;  // nothing accepted in the load cycle
    load      = 1'b1;
    @(negedge AnalogClock);
    load = 1'b0;
    while (!row_done)
    begin
      pix_ready = ready_draw(tab[r].duty);
      @(negedge AnalogClock);
    end
  endtask

  always @(posedge AnalogClock)
  begin
    cycles++;
    if (cycles > limit)
    begin
      $display("timeout: run did not finish within %0d cycles", limit);
      print_counts();
      $display("Test FAILED");
      $finish;
    end
  end

  initial
  begin
    void'($urandom(32'he378fab8));
    AnalogClock = 1'b0;
    reset       = 1'b1;
    load        = 1'b0;
    k1          = '0;
    kmid        = '0;
    k2          = '0;
    damp        = '0;
    x1_init     = '0;
    x2_init     = '0;
    v1_init     = '0;
    v2_init     = '0;
    pix_ready   = 1'b0;
    target      = 0;
    exp_col     = '0;
    cycles      = 0;
    // k1 kmid k2 damp, x1 x2 v1 v2 inits, samples, duty, end column
    tab[0] = '{18'h08000, 18'h04000, 18'h08000, 18'h00290,
               18'h10000, 18'h38000, 18'h00000, 18'h00000, 20, 100, 20};
    tab[1] = '{18'h0C000, 18'h02000, 18'h04000, 18'h00000,
               18'h34000, 18'h08000, 18'h04000, 18'h3C000, 30, 30, 30};
    tab[2] = '{18'h08000, 18'h08000, 18'h08000, 18'h00100,
               18'h18000, 18'h00000, 18'h00000, 18'h00000, 60, 100, 12};
    tab[3] = '{18'h08000, 18'h00000, 18'h08000, 18'h00000,
               18'h14000, 18'h14000, 18'h3E000, 18'h3E000, 25, 70, 25};  // mirrored masses
    tab[4] = '{18'h0C000, 18'h04000, 18'h04000, 18'h00200,
               18'h3C000, 18'h0C000, 18'h08000, 18'h00000, 5, 100, 5};
    tab[5] = '{18'h04000, 18'h02000, 18'h0C000, 18'h00080,
               18'h30000, 18'h10000, 18'h00000, 18'h04000, 50, 30, 2};
    limit = 0;
    foreach (tab[r])
      limit += tab[r].samples * (STEP_DIV + 2) * 4 + 20;
    repeat (3) @(negedge AnalogClock);
    reset = 1'b0;
    foreach (tab[r])
      run_row(r);
    print_counts();
    if (write_errs + row_errs + i_dut.i_solver.i_credit_chk.assert_errs == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/plot_scoreboard.sv
`timescale 1ns/1ps
`default_nettype none

module plot_scoreboard #(
  parameter int DT_SHIFT = 9,
  parameter int SCREEN_W = 640,
  parameter int X1_ROW   = 160,
  parameter int X2_ROW   = 400
) (
  input  logic                       AnalogClock,
  input  logic                       reset,
  input  logic                       load,
  input  osc_pkg::state_t            k1,
  input  osc_pkg::state_t            kmid,
  input  osc_pkg::state_t            k2,
  input  osc_pkg::state_t            damp,
  input  osc_pkg::state_t            x1_init,
  input  osc_pkg::state_t            x2_init,
  input  osc_pkg::state_t            v1_init,
  input  osc_pkg::state_t            v2_init,
  input  logic                       pix_valid,
  input  logic                       pix_ready,
  input  logic [plot_pkg::COL_W-1:0] pix_col,
  input  logic [plot_pkg::ROW_W-1:0] pix_row,
  input  logic                       pix_trace,
  input  int                         target,  // samples in the current table row
  input  logic [plot_pkg::COL_W-1:0] exp_col,
  output logic                       row_done,
  output int                         write_errs,
  output int                         row_errs
);
  import osc_pkg::*;
  import plot_pkg::*;

  state_t m_x1;  // model state
  state_t m_x2;
  state_t m_v1;
  state_t m_v2;
  int     seen;
  int     col_m;
  int     ofs1;  // x1 offset of the sample in flight
  logic   want_x2;
  logic   symmetric;

  initial
  begin
    write_errs = 0;
    row_errs   = 0;
    row_done   = 1'b0;
  end

  // middle 18 bits of the 36 bit signed product
  function automatic state_t fixed_mul(input state_t a, input state_t b);
    logic signed [2*STATE_W-1:0] p;
    p = a * b;
    return p[FRAC_W +: STATE_W];
  endfunction

  function automatic int expected_row(input int base, input state_t pos);
    int ofs;
    ofs = pos >>> (STATE_W - ROW_BITS);  // top bits as a signed offset
    return base + ofs;
  endfunction

  // one Euler step, positions move with the old velocities
  task automatic advance_model();
    state_t c;
    state_t a1;
    state_t a2;
    c    = fixed_mul(kmid, state_t'(m_x2 - m_x1));
    a1   = c - fixed_mul(k1, m_x1) - fixed_mul(damp, m_v1);
    a2   = state_t'(0) - c - fixed_mul(k2, m_x2) - fixed_mul(damp, m_v2);
    m_x1 = m_x1 + (m_v1 >>> DT_SHIFT);
    m_x2 = m_x2 + (m_v2 >>> DT_SHIFT);
    m_v1 = m_v1 + (a1 >>> DT_SHIFT);
    m_v2 = m_v2 + (a2 >>> DT_SHIFT);
  endtask

  task automatic check_field(input string name, input int exp, input int act);
    if (exp != act)
    begin
      $display("CHECK FAILED %s: expected 0x%h, got 0x%h (sample %0d)", name, exp, act, seen);
      write_errs++;
    end
  endtask

  always @(posedge AnalogClock)
  begin
    if (reset || load)
    begin
      m_x1      = x1_init;
      m_x2      = x2_init;
      m_v1      = v1_init;
      m_v2      = v2_init;
      symmetric = (kmid == '0) && (damp == '0) && (k1 == k2) &&
                  (x1_init == x2_init) && (v1_init == v2_init);
      seen      = 0;
      col_m     = 0;
      want_x2   = 1'b0;
      row_done  = 1'b0;
    end
    else
    begin
      // column has settled one cycle after the last x2 write
      if (!row_done && seen == target)
      begin
        if (pix_col != exp_col)
        begin
          $display("CHECK FAILED pix_col at row end: expected 0x%h, got 0x%h", exp_col, pix_col);
          row_errs++;
        end
        row_done = 1'b1;
      end
      if (pix_valid && pix_ready)
      begin
        check_field("pix_trace", want_x2, pix_trace);
        check_field("pix_col", col_m, pix_col);
        if (!want_x2)
        begin
          advance_model();
          check_field("pix_row", expected_row(X1_ROW, m_x1), pix_row);
          ofs1 = int'(pix_row) - X1_ROW;
        end
        else
        begin
          check_field("pix_row", expected_row(X2_ROW, m_x2), pix_row);
          if (symmetric)
            check_field("pix_row offset", ofs1, int'(pix_row) - X2_ROW);
          col_m = (col_m == SCREEN_W - 1) ? 0 : col_m + 1;
          seen++;
        end
        want_x2 = !want_x2;
      end
    end
  end

endmodule

`default_nettype wire

//--- sim/credit_chk.sv
`timescale 1ns/1ps
`default_nettype none

module credit_chk #(
  parameter int FIFO_DEPTH = 8
) (
  input logic                              AnalogClock,
  input logic                              reset,
  input logic                              load,
  input logic                              push,
  input logic                              credit_return,
  input logic [$clog2(FIFO_DEPTH+1)-1:0]   credits
);
  localparam int CRED_W = $clog2(FIFO_DEPTH + 1);

  int                assert_errs = 0;  // failed assertions
  logic [CRED_W-1:0] loop_credits;     // free slots rebuilt from push and credit_return

  always_ff @(posedge AnalogClock)
  begin
    if (reset || load)
      loop_credits <= CRED_W'(FIFO_DEPTH);
    else if (push && !credit_return)
      loop_credits <= loop_credits - 1'b1;
    else if (credit_return && !push)
      loop_credits <= loop_credits + 1'b1;
  end

  // a wrap below zero would also land above FIFO_DEPTH
  credit_max: assert property (@(posedge AnalogClock) disable iff (reset)
    credits <= FIFO_DEPTH)
  else
  begin
    $error("credit count above fifo depth");
    assert_errs++;
  end

  credit_floor: assert property (@(posedge AnalogClock) disable iff (reset || load)
    (credits == '0) |=> (credits <= 1))
  else
  begin
    $error("credit count went below zero");
    assert_errs++;
  end

  push_needs_credit: assert property (@(posedge AnalogClock) disable iff (reset)
    push |-> (loop_credits != '0))
  else
  begin
    $error("push with no credit left");
    assert_errs++;
  end

  quiet_after_reset: assert property (@(posedge AnalogClock)
    reset |=> !push)
  else
  begin
    $error("push high in the cycle after reset");
    assert_errs++;
  end

endmodule

bind spring_solver credit_chk #(
  .FIFO_DEPTH (FIFO_DEPTH)
) i_credit_chk (
  .AnalogClock   (AnalogClock),
  .reset         (reset),
  .load          (load),
  .push          (push),
  .credit_return (credit_return),
  .credits       (credits)
);

`default_nettype wire

//--- source/oscillator_display.sv
`timescale 1ns/1ps
`default_nettype none

module oscillator_display #(
  parameter int FIFO_DEPTH = 8,  // power of two
  parameter int DT_SHIFT   = 9,
  parameter int STEP_DIV   = 32,
  parameter int SCREEN_W   = 640,
  parameter int X1_ROW     = 160,
  parameter int X2_ROW     = 400
) (
  input  logic                       AnalogClock,
  input  logic                       reset,
  input  logic                       load,
  input  osc_pkg::state_t            k1,
  input  osc_pkg::state_t            kmid,
  input  osc_pkg::state_t            k2,
  input  osc_pkg::state_t            damp,
  input  osc_pkg::state_t            x1_init,
  input  osc_pkg::state_t            x2_init,
  input  osc_pkg::state_t            v1_init,
  input  osc_pkg::state_t            v2_init,
  input  logic                       pix_ready,
  output logic                       pix_valid,
  output logic [plot_pkg::COL_W-1:0] pix_col,
  output logic [plot_pkg::ROW_W-1:0] pix_row,
  output logic                       pix_trace
);
  import osc_pkg::*;

  logic   push;
  state_t s_x1;
  state_t s_x2;
  logic   credit_return;
  logic   not_empty;
  state_t q_x1;
  state_t q_x2;
  logic   pop;

  spring_solver #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .DT_SHIFT   (DT_SHIFT),
    .STEP_DIV   (STEP_DIV)
  ) i_solver (
    .AnalogClock   (AnalogClock),
    .reset         (reset),
    .load          (load),
    .k1            (k1),
    .kmid          (kmid),
    .k2            (k2),
    .damp          (damp),
    .x1_init       (x1_init),
    .x2_init       (x2_init),
    .v1_init       (v1_init),
    .v2_init       (v2_init),
    .credit_return (credit_return),
    .push          (push),
    .s_x1          (s_x1),
    .s_x2          (s_x2)
  );

  // load also flushes buffered samples
  sample_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_fifo (
    .AnalogClock   (AnalogClock),
    .reset         (reset),
    .clear         (load),
    .push          (push),
    .d_x1          (s_x1),
    .d_x2          (s_x2),
    .pop           (pop),
    .not_empty     (not_empty),
    .q_x1          (q_x1),
    .q_x2          (q_x2),
    .credit_return (credit_return)
  );

  trace_plotter #(
    .SCREEN_W (SCREEN_W),
    .X1_ROW   (X1_ROW),
    .X2_ROW   (X2_ROW)
  ) i_plotter (
    .AnalogClock (AnalogClock),
    .reset       (reset),
    .clear       (load),
    .not_empty   (not_empty),
    .q_x1        (q_x1),
    .q_x2        (q_x2),
    .pop         (pop),
    .pix_ready   (pix_ready),
    .pix_valid   (pix_valid),
    .pix_col     (pix_col),
    .pix_row     (pix_row),
    .pix_trace   (pix_trace)
  );

endmodule

`default_nettype wire

//--- source/trace_plotter.sv
`timescale 1ns/1ps
`default_nettype none

module trace_plotter #(
  parameter int SCREEN_W = 640,
  parameter int X1_ROW   = 160,
  parameter int X2_ROW   = 400
) (
  input  logic                       AnalogClock,
  input  logic                       reset,
  input  logic                       clear,
  input  logic                       not_empty,
  input  osc_pkg::state_t            q_x1,
  input  osc_pkg::state_t            q_x2,
  output logic                       pop,
  input  logic                       pix_ready,
  output logic                       pix_valid,
  output logic [plot_pkg::COL_W-1:0] pix_col,
  output logic [plot_pkg::ROW_W-1:0] pix_row,
  output logic                       pix_trace
);
  import osc_pkg::*;
  import plot_pkg::*;

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_X1   = 2'd1;
  localparam logic [1:0] ST_X2   = 2'd2;

  localparam logic [ROW_W-1:0] X1_BASE  = ROW_W'(X1_ROW);
  localparam logic [ROW_W-1:0] X2_BASE  = ROW_W'(X2_ROW);
  localparam logic [COL_W-1:0] LAST_COL = COL_W'(SCREEN_W - 1);

  logic [1:0]       state;
  logic [COL_W-1:0] col;
  state_t           lat_x1;  // sample taken at pop
  state_t           lat_x2;
  state_t           cur_pos;
  logic [ROW_W-1:0] cur_base;

  assign pop = (state == ST_IDLE) && not_empty;

  // write fields come straight from registers, so they hold under back-pressure
  assign cur_pos   = (state == ST_X2) ? lat_x2 : lat_x1;
  assign cur_base  = (state == ST_X2) ? X2_BASE : X1_BASE;
  assign pix_valid = (state != ST_IDLE);
  assign pix_trace = (state == ST_X2);  // 0 is the x1 trace
  assign pix_col   = col;
  assign pix_row   = trace_row(cur_base, cur_pos[STATE_W-1 -: ROW_BITS]);

  always_ff @(posedge AnalogClock)
  begin
    if (pop)
    begin
      lat_x1 <= q_x1;
      lat_x2 <= q_x2;
    end
  end

  always_ff @(posedge AnalogClock)
  begin
    if (reset || clear)
    begin
      state <= ST_IDLE;
      col   <= '0;
    end
    else
    begin
      case (state)
        ST_IDLE:
          if (not_empty)
            state <= ST_X1;
        ST_X1:
          if (pix_ready)
            state <= ST_X2;
        ST_X2:
          if (pix_ready)
          begin
            state <= ST_IDLE;
            col   <= (col == LAST_COL) ? '0 : col + 1'b1;  // next sample column
          end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/sample_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sample_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic            AnalogClock,
  input  logic            reset,
  input  logic            clear,
  input  logic            push,
  input  osc_pkg::state_t d_x1,
  input  osc_pkg::state_t d_x2,
  input  logic            pop,
  output logic            not_empty,
  output osc_pkg::state_t q_x1,
  output osc_pkg::state_t q_x2,
  output logic            credit_return
);
  import osc_pkg::*;

  localparam int ADDR_W = $clog2(FIFO_DEPTH);

  state_t mem_x1 [FIFO_DEPTH];
  state_t mem_x2 [FIFO_DEPTH];

  // one extra pointer bit tells full from empty
  logic [ADDR_W:0] wr_ptr;
  logic [ADDR_W:0] rd_ptr;
  logic            wr_en;
  logic            rd_en;

  assign wr_en = push && !clear;  // credit loop keeps the buffer from overflowing
  assign rd_en = pop && not_empty && !clear;

  assign not_empty = (wr_ptr != rd_ptr);
  assign q_x1      = mem_x1[rd_ptr[ADDR_W-1:0]];  // oldest entry
  assign q_x2      = mem_x2[rd_ptr[ADDR_W-1:0]];

  always_ff @(posedge AnalogClock)
  begin
    if (wr_en)
    begin
      mem_x1[wr_ptr[ADDR_W-1:0]] <= d_x1;
      mem_x2[wr_ptr[ADDR_W-1:0]] <= d_x2;
    end
  end

  always_ff @(posedge AnalogClock)
  begin
    if (reset || clear)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // one credit back per entry read out
  always_ff @(posedge AnalogClock)
  begin
    if (reset || clear)
      credit_return <= 1'b0;
    else
      credit_return <= rd_en;
  end

endmodule

`default_nettype wire

//--- source/spring_solver.sv
`timescale 1ns/1ps
`default_nettype none

module spring_solver #(
  parameter int FIFO_DEPTH = 8,
  parameter int DT_SHIFT   = 9,
  parameter int STEP_DIV   = 32
) (
  input  logic            AnalogClock,
  input  logic            reset,
  input  logic            load,
  input  osc_pkg::state_t k1,
  input  osc_pkg::state_t kmid,
  input  osc_pkg::state_t k2,
  input  osc_pkg::state_t damp,
  input  osc_pkg::state_t x1_init,
  input  osc_pkg::state_t x2_init,
  input  osc_pkg::state_t v1_init,
  input  osc_pkg::state_t v2_init,
  input  logic            credit_return,
  output logic            push,
  output osc_pkg::state_t s_x1,
  output osc_pkg::state_t s_x2
);
  import osc_pkg::*;

  localparam int CRED_W = $clog2(FIFO_DEPTH + 1);
  localparam int STEP_W = (STEP_DIV > 1) ? $clog2(STEP_DIV) : 1;

  state_t x1;
  state_t x2;
  state_t v1;
  state_t v2;

  state_t dx;
  state_t coupling;
  state_t a1;
  state_t a2;
  state_t x1_next;
  state_t x2_next;
  state_t v1_next;
  state_t v2_next;

  logic [STEP_W-1:0] step_cnt;
  logic              step_opp;
  logic              step_pend;  // opportunity waiting for a credit
  logic              do_step;
  logic [CRED_W-1:0] credits;

  // one Euler step, both masses share the coupling term
  always_comb
  begin
    dx       = x2 - x1;
    coupling = fx_mul(kmid, dx);
    a1       = coupling - fx_mul(k1, x1) - fx_mul(damp, v1);
    a2       = -coupling - fx_mul(k2, x2) - fx_mul(damp, v2);
    v1_next  = v1 + (a1 >>> DT_SHIFT);
    v2_next  = v2 + (a2 >>> DT_SHIFT);
    x1_next  = x1 + (v1 >>> DT_SHIFT);  // uses the old velocity
    x2_next  = x2 + (v2 >>> DT_SHIFT);
  end

  assign step_opp = (step_cnt == STEP_W'(STEP_DIV - 1));
  assign do_step  = (step_opp || step_pend) && (credits != '0) && !load;

  // sample goes out in the same cycle the states advance
  assign push = do_step;
  assign s_x1 = x1_next;
  assign s_x2 = x2_next;

  // free running step enable counter
  always_ff @(posedge AnalogClock)
  begin
    if (reset)
      step_cnt <= '0;
    else if (step_opp)
      step_cnt <= '0;
    else
      step_cnt <= step_cnt + 1'b1;
  end

  always_ff @(posedge AnalogClock)
  begin
    if (reset || load)
      step_pend <= 1'b0;
    else if (do_step)
      step_pend <= 1'b0;
    else if (step_opp)
      step_pend <= 1'b1;  // no credit, hold the step
  end

  // credits mirror the free fifo slots
  always_ff @(posedge AnalogClock)
  begin
    if (reset || load)
      credits <= CRED_W'(FIFO_DEPTH);
    else
    begin
      case ({credit_return, do_step})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;  // none or both
      endcase
    end
  end

  always_ff @(posedge AnalogClock)
  begin
    if (reset || load)
    begin
      x1 <= x1_init;
      x2 <= x2_init;
      v1 <= v1_init;
      v2 <= v2_init;
    end
    else if (do_step)
    begin
      x1 <= x1_next;
      x2 <= x2_next;
      v1 <= v1_next;
      v2 <= v2_next;
    end
  end

endmodule

`default_nettype wire

//--- source/plot_pkg.sv
`default_nettype none

package plot_pkg;

  // 640 x 480 screen fits these coordinate widths
  localparam int COL_W = 10;
  localparam int ROW_W = 9;

  // top position bits used as row offset, about +-16 rows of swing
  localparam int ROW_BITS = 5;

  // base row of a trace plus the signed offset, sign extended to ROW_W
  function automatic logic [ROW_W-1:0] trace_row(
    input logic        [ROW_W-1:0]    base,
    input logic signed [ROW_BITS-1:0] ofs
  );
    return base + {{(ROW_W - ROW_BITS){ofs[ROW_BITS-1]}}, ofs};
  endfunction

endpackage

`default_nettype wire

//--- source/osc_pkg.sv
`default_nettype none

package osc_pkg;

  // signed fixed point, 2 integer bits and 16 fraction bits
  localparam int STATE_W = 18;
  localparam int FRAC_W  = 16;

  // full width of one coefficient times state product
  localparam int PROD_W = 2 * STATE_W;

  typedef logic signed [STATE_W-1:0] state_t;

  // fixed point multiply
  // full signed product, arithmetic shift by FRAC_W, low STATE_W bits kept
  function automatic state_t fx_mul(
    input state_t a,
    input state_t b
  );
    logic signed [PROD_W-1:0] prod;
    prod = a * b;
    return state_t'(prod >>> FRAC_W);
  endfunction

endpackage

`default_nettype wire
